//--- hdl/vga_pkg.sv
`default_nettype none

package vga_pkg;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // 640x480 at 60 Hz, 25 MHz pixel clock
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    localparam int H_ACTIVE = 640;
    localparam int H_FRONT  = 16;
    localparam int H_SYNC   = 96;
    localparam int H_BACK   = 48;
    localparam int H_TOTAL  = H_ACTIVE + H_FRONT + H_SYNC + H_BACK;  // 800

    localparam int V_ACTIVE = 480;
    localparam int V_FRONT  = 10;
    localparam int V_SYNC   = 2;
    localparam int V_BACK   = 33;
    localparam int V_TOTAL  = V_ACTIVE + V_FRONT + V_SYNC + V_BACK;  // 525

    localparam int HS_START = H_ACTIVE + H_FRONT;                     // 656
    localparam int HS_END   = HS_START + H_SYNC;                      // First pixel after pulse
    localparam int VS_START = V_ACTIVE + V_FRONT;                     // 490
    localparam int VS_END   = VS_START + V_SYNC;                      // First line after pulse

    localparam int POS_W    = 10;
    localparam int COLOR_W  = 4;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Pattern geometry and star generator
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    localparam int RING_OFFSET = 5;
    localparam int MARGIN      = 20;
    localparam int STAR_SIZE   = 256;

    localparam int                  LFSR_W    = 16;
    localparam logic [LFSR_W-1:0]   LFSR_TAPS = 16'b1000000001011;
    localparam logic [LFSR_W-1:0]   LFSR_SEED = 16'h0001;          // Must not be zero

endpackage

`default_nettype wire

//--- hdl/vga_timing.sv
`timescale 1ns/1ps
`default_nettype none

module vga_timing
    import vga_pkg::*;
(
    input  logic             clk,
    input  logic             rst,
    output logic [POS_W-1:0] hpos,
    output logic [POS_W-1:0] vpos,
    output logic             display_on,
    output logic             hsync,
    output logic             vsync
);

    logic [POS_W-1:0] h_next;
    logic [POS_W-1:0] v_next;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Next position
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    always_comb begin
        h_next = hpos + 1'b1;
        v_next = vpos;
        if (hpos == POS_W'(H_TOTAL - 1)) begin
            h_next = '0;                                   // End of line
            if (vpos == POS_W'(V_TOTAL - 1)) begin
                v_next = '0;                               // End of frame
            end else begin
                v_next = vpos + 1'b1;
            end
        end
    end

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Counters and per-pixel flags
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Flags are decoded from h_next/v_next so they land in the same cycle
    // as the position they describe
    always_ff @(posedge clk) begin
        if (rst) begin
            hpos       <= '0;
            vpos       <= '0;
            display_on <= 1'b1;                            // (0,0) is visible
            hsync      <= 1'b1;
            vsync      <= 1'b1;
        end else begin
            hpos       <= h_next;
            vpos       <= v_next;
            display_on <= (h_next < POS_W'(H_ACTIVE)) && (v_next < POS_W'(V_ACTIVE));
            hsync      <= !((h_next >= POS_W'(HS_START)) && (h_next < POS_W'(HS_END)));
            vsync      <= !((v_next >= POS_W'(VS_START)) && (v_next < POS_W'(VS_END)));
        end
    end

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Checks
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    a_pos_range : assert property (
        @(posedge clk) disable iff (rst)
        (hpos < POS_W'(H_TOTAL)) && (vpos < POS_W'(V_TOTAL))
    ) else $error("vga_timing: position out of range (%0d,%0d)", hpos, vpos);

    a_hsync_window : assert property (
        @(posedge clk) disable iff (rst)
        !hsync |-> ((hpos >= POS_W'(HS_START)) && (hpos < POS_W'(HS_END)))
    ) else $error("vga_timing: hsync low at hpos %0d", hpos);

endmodule

`default_nettype wire

//--- hdl/lfsr_galois.sv
`timescale 1ns/1ps
`default_nettype none

module lfsr_galois
    import vga_pkg::*;
(
    input  logic              clk,
    input  logic              rst,
    input  logic              enable,
    output logic [LFSR_W-1:0] state
);

    logic [LFSR_W-1:0] shifted;
    logic [LFSR_W-1:0] state_next;

    always_comb begin
        shifted    = {state[LFSR_W-2:0], 1'b0};
        state_next = shifted;
        if (state[LFSR_W-1]) begin
            state_next = shifted ^ LFSR_TAPS;              // Feedback on the dropped MSB
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            state <= LFSR_SEED;
        end else if (enable) begin
            state <= state_next;
        end
    end

    // Zero is a lock-up state of the Galois form
    a_state_nonzero : assert property (
        @(posedge clk) disable iff (rst)
        state != '0
    ) else $error("lfsr_galois: state reached zero");

endmodule

`default_nettype wire

//--- hdl/test_pattern.sv
`timescale 1ns/1ps
`default_nettype none

module test_pattern
    import vga_pkg::*;
(
    input  logic             clk,
    input  logic             rst,
    input  logic [POS_W-1:0] hpos,
    input  logic [POS_W-1:0] vpos,
    output logic [2:0]       color
);

    logic [2:0] rgb;
    logic       in_margin;

    // True on the ring drawn off pixels in from every edge
    function automatic logic on_ring(input logic [POS_W-1:0] x,
                                     input logic [POS_W-1:0] y,
                                     input int               off);
        return (x == POS_W'(off)) || (x == POS_W'(H_ACTIVE - 1 - off)) ||
               (y == POS_W'(off)) || (y == POS_W'(V_ACTIVE - 1 - off));
    endfunction

    // Bottom margin reaches one line further up than the other three
    assign in_margin = (hpos <  POS_W'(MARGIN))                ||
                       (hpos >  POS_W'(H_ACTIVE - 1 - MARGIN)) ||
                       (vpos <  POS_W'(MARGIN))                ||
                       (vpos >= POS_W'(V_ACTIVE - 1 - MARGIN));

    always_comb begin
        if (on_ring(hpos, vpos, 0)) begin
            rgb = 3'b100;                                  // Red, outer edge
        end else if (on_ring(hpos, vpos, RING_OFFSET)) begin
            rgb = 3'b010;                                  // Green
        end else if (on_ring(hpos, vpos, 2 * RING_OFFSET)) begin
            rgb = 3'b001;                                  // Blue
        end else if (in_margin) begin
            rgb = 3'b000;
        end else begin
            rgb = {1'b0, vpos[4], hpos[3] ^ vpos[3]};      // Checkerboard
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            color <= 3'b000;
        end else begin
            color <= rgb;
        end
    end

endmodule

`default_nettype wire

//--- hdl/starfield.sv
`timescale 1ns/1ps
`default_nettype none

module starfield
    import vga_pkg::*;
(
    input  logic             clk,
    input  logic             rst,
    input  logic [POS_W-1:0] hpos,
    input  logic [POS_W-1:0] vpos,
    output logic             star_region,
    output logic [2:0]       color
);

    logic              region;
    logic [LFSR_W-1:0] lfsr_state;
    logic              star_on;
    logic [2:0]        star_rgb;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Region decode and noise source
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    assign region = (hpos < POS_W'(STAR_SIZE)) && (vpos < POS_W'(STAR_SIZE));

    // Steps once per pixel inside the square, so the sequence carries
    // on from one frame to the next
    lfsr_galois i_lfsr (
        .clk    (clk),
        .rst    (rst),
        .enable (region),
        .state  (lfsr_state)
    );

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Star colour
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    assign star_on  = &lfsr_state[15:9];                   // About 1 in 128 pixels
    assign star_rgb = star_on ? lfsr_state[2:0] : 3'b000;  // State before this step

    always_ff @(posedge clk) begin
        if (rst) begin
            star_region <= 1'b0;
            color       <= 3'b000;
        end else begin
            star_region <= region;
            color       <= star_rgb;
        end
    end

endmodule

`default_nettype wire

//--- hdl/vga_pattern_top.sv
`timescale 1ns/1ps
`default_nettype none

module vga_pattern_top
    import vga_pkg::*;
(
    input  logic               clk,
    input  logic               rst,
    output logic               hsync,
    output logic               vsync,
    output logic [COLOR_W-1:0] red,
    output logic [COLOR_W-1:0] green,
    output logic [COLOR_W-1:0] blue
);

    logic [POS_W-1:0] hpos;
    logic [POS_W-1:0] vpos;
    logic             display_on;
    logic             hsync_raw;
    logic             vsync_raw;

    logic [2:0]       pattern_color;
    logic [2:0]       star_color;
    logic             star_region;

    logic             display_on_d;
    logic             hsync_d;
    logic             vsync_d;
    logic [2:0]       pixel;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Sources
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    vga_timing i_timing (
        .clk        (clk),
        .rst        (rst),
        .hpos       (hpos),
        .vpos       (vpos),
        .display_on (display_on),
        .hsync      (hsync_raw),
        .vsync      (vsync_raw)
    );

    test_pattern i_pattern (
        .clk   (clk),
        .rst   (rst),
        .hpos  (hpos),
        .vpos  (vpos),
        .color (pattern_color)
    );

    starfield i_stars (
        .clk         (clk),
        .rst         (rst),
        .hpos        (hpos),
        .vpos        (vpos),
        .star_region (star_region),
        .color       (star_color)
    );

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Pixel mixer, two stages from position to pins
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    always_comb begin
        pixel = star_region ? star_color : pattern_color;
        if (!display_on_d) begin
            pixel = 3'b000;                                // Blanking
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            display_on_d <= 1'b0;
            hsync_d      <= 1'b1;
            vsync_d      <= 1'b1;
            hsync        <= 1'b1;
            vsync        <= 1'b1;
            red          <= '0;
            green        <= '0;
            blue         <= '0;
        end else begin
            display_on_d <= display_on;                    // Same stage as the colours
            hsync_d      <= hsync_raw;
            vsync_d      <= vsync_raw;
            hsync        <= hsync_d;
            vsync        <= vsync_d;
            red          <= {COLOR_W{pixel[2]}};
            green        <= {COLOR_W{pixel[1]}};
            blue         <= {COLOR_W{pixel[0]}};
        end
    end

    a_blank_outside_active : assert property (
        @(posedge clk) disable iff (rst)
        !display_on_d |=> ((red == '0) && (green == '0) && (blue == '0))
    ) else $error("vga_pattern_top: colour driven during blanking");

endmodule

`default_nettype wire

//--- verification/tb_vga_pattern.sv
`timescale 1ns/1ps
`default_nettype none

module tb_vga_pattern
    import vga_pkg::*;
();

    localparam int CLK_PERIOD     = 20;
    localparam int DRIVE_DELAY    = 1;
    localparam int RESET_CYCLES   = 16;
    localparam int FRAME_CYCLES   = V_TOTAL * H_TOTAL;
    localparam int TIMEOUT_CYCLES = 2 * FRAME_CYCLES + 100;

    localparam int N_TESTS   = 6;
    localparam int T_HSYNC   = 0;
    localparam int T_VSYNC   = 1;
    localparam int T_BLANK   = 2;
    localparam int T_BORDER  = 3;
    localparam int T_CHECKER = 4;
    localparam int T_STARS   = 5;

    logic               clk;
    logic               rst;
    logic               hsync;
    logic               vsync;
    logic [COLOR_W-1:0] red;
    logic [COLOR_W-1:0] green;
    logic [COLOR_W-1:0] blue;

    string test_name [N_TESTS] = '{"hsync", "vsync", "blanking", "border", "checker", "stars"};
    int    chk_cnt [N_TESTS];
    int    err_cnt [N_TESTS];
    int    cycle;

    int                   m_h;                             // Model position
    int                   m_v;
    int                   frame_cnt;
    logic [LFSR_W-1:0]    m_lfsr;
    logic                 v1;                              // Two-stage expectation pipeline
    logic                 v2;
    logic                 e1_hs;
    logic                 e2_hs;
    logic                 e1_vs;
    logic                 e2_vs;
    int                   e1_cls;
    int                   e2_cls;
    logic [3*COLOR_W-1:0] e1_rgb;
    logic [3*COLOR_W-1:0] e2_rgb;

    logic                 hs_prev;                         // Sync pulse measurement
    logic                 vs_prev;
    logic                 hs_seen;
    logic                 vs_seen;
    int                   hs_low_cnt;
    int                   vs_low_cnt;
    int                   hs_gap;
    int                   vs_gap;

    vga_pattern_top uut (
        .clk   (clk),
        .rst   (rst),
        .hsync (hsync),
        .vsync (vsync),
        .red   (red),
        .green (green),
        .blue  (blue)
    );

    always #(CLK_PERIOD / 2) clk = ~clk;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Reference rules
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    function automatic logic [LFSR_W-1:0] lfsr_step(input logic [LFSR_W-1:0] s);
        logic [LFSR_W-1:0] r;
        r = s << 1;
        if (s[LFSR_W-1])
            r = r ^ LFSR_TAPS;
        return r;
    endfunction

    function automatic logic [2:0] star_pixel(input logic [LFSR_W-1:0] s);
        if (s[15:9] == 7'h7f)
            return s[2:0];
        return 3'b000;
    endfunction

    function automatic int pixel_class(input int x, input int y);
        if (x >= H_ACTIVE || y >= V_ACTIVE)
            return T_BLANK;
        if (x < STAR_SIZE && y < STAR_SIZE)
            return T_STARS;
        if (x < MARGIN || x > H_ACTIVE - 1 - MARGIN || y < MARGIN || y >= V_ACTIVE - 1 - MARGIN)
            return T_BORDER;
        return T_CHECKER;
    endfunction

    function automatic logic [2:0] border_color(input int x, input int y);
        int right;
        int bottom;
        right  = H_ACTIVE - 1;
        bottom = V_ACTIVE - 1;
        if (x == 0 || x == right || y == 0 || y == bottom)
            return 3'b100;
        if (x == RING_OFFSET || x == right - RING_OFFSET ||
            y == RING_OFFSET || y == bottom - RING_OFFSET)
            return 3'b010;
        if (x == 2 * RING_OFFSET || x == right - 2 * RING_OFFSET ||
            y == 2 * RING_OFFSET || y == bottom - 2 * RING_OFFSET)
            return 3'b001;
        return 3'b000;                                     // Black margin
    endfunction

    function automatic logic [2:0] expected_color(input int x, input int y,
                                                  input logic [LFSR_W-1:0] s);
        case (pixel_class(x, y))
            T_STARS:   return star_pixel(s);
            T_BORDER:  return border_color(x, y);
            T_CHECKER: return {1'b0, y[4], x[3] ^ y[3]};
            default:   return 3'b000;
        endcase
    endfunction

    function automatic logic [3*COLOR_W-1:0] widen(input logic [2:0] c);
        return {{COLOR_W{c[2]}}, {COLOR_W{c[1]}}, {COLOR_W{c[0]}}};
    endfunction

    task automatic report_mismatch(input int test, input logic [31:0] expected,
                                   input logic [31:0] actual);
        err_cnt[test] = err_cnt[test] + 1;
        $display("error: test %s expected %0h actual %0h at %0t",
                 test_name[test], expected, actual, $time);
    endtask

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Model and sync measurement
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    always @(posedge clk) begin
        if (rst) begin
            m_h        <= 0;
            m_v        <= 0;
            frame_cnt  <= 0;
            m_lfsr     <= LFSR_SEED;
            v1         <= 1'b0;
            v2         <= 1'b0;
            hs_prev    <= 1'b1;
            vs_prev    <= 1'b1;
            hs_seen    <= 1'b0;
            vs_seen    <= 1'b0;
            hs_low_cnt <= 0;
            vs_low_cnt <= 0;
            hs_gap     <= 0;
            vs_gap     <= 0;
        end else begin
            v1     <= 1'b1;
            e1_hs  <= !(m_h >= H_ACTIVE + H_FRONT && m_h < H_ACTIVE + H_FRONT + H_SYNC);
            e1_vs  <= !(m_v >= V_ACTIVE + V_FRONT && m_v < V_ACTIVE + V_FRONT + V_SYNC);
            e1_cls <= pixel_class(m_h, m_v);
            e1_rgb <= widen(expected_color(m_h, m_v, m_lfsr));
            v2     <= v1;
            e2_hs  <= e1_hs;
            e2_vs  <= e1_vs;
            e2_cls <= e1_cls;
            e2_rgb <= e1_rgb;
            if (m_h < STAR_SIZE && m_v < STAR_SIZE)
                m_lfsr <= lfsr_step(m_lfsr);               // Never reseeded between frames
            if (m_h == H_TOTAL - 1) begin
                m_h <= 0;
                if (m_v == V_TOTAL - 1) begin
                    m_v       <= 0;
                    frame_cnt <= frame_cnt + 1;
                end else begin
                    m_v <= m_v + 1;
                end
            end else begin
                m_h <= m_h + 1;
            end

            hs_prev    <= hsync;
            vs_prev    <= vsync;
            hs_low_cnt <= hsync ? 0 : hs_low_cnt + 1;
            vs_low_cnt <= vsync ? 0 : vs_low_cnt + 1;
            hs_gap     <= (hs_prev && !hsync) ? 1 : hs_gap + 1;
            vs_gap     <= (vs_prev && !vsync) ? 1 : vs_gap + 1;
            if (hs_prev && !hsync)
                hs_seen <= 1'b1;
            if (vs_prev && !vsync)
                vs_seen <= 1'b1;

            // Same conditions as the assertions below
            if (v2) begin
                chk_cnt[T_HSYNC] = chk_cnt[T_HSYNC] + 1;
                chk_cnt[T_VSYNC] = chk_cnt[T_VSYNC] + 1;
                chk_cnt[e2_cls]  = chk_cnt[e2_cls] + 1;
            end
            if (hsync && !hs_prev)
                chk_cnt[T_HSYNC] = chk_cnt[T_HSYNC] + 1;
            if (!hsync && hs_prev && hs_seen)
                chk_cnt[T_HSYNC] = chk_cnt[T_HSYNC] + 1;
            if (vsync && !vs_prev)
                chk_cnt[T_VSYNC] = chk_cnt[T_VSYNC] + 1;
            if (!vsync && vs_prev && vs_seen)
                chk_cnt[T_VSYNC] = chk_cnt[T_VSYNC] + 1;
        end
    end

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Checks
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    a_hsync_level : assert property (@(posedge clk) disable iff (rst)
        v2 |-> (hsync == e2_hs)
    ) else report_mismatch(T_HSYNC, $sampled(e2_hs), $sampled(hsync));

    a_hsync_width : assert property (@(posedge clk) disable iff (rst)
        $rose(hsync) |-> (hs_low_cnt == H_SYNC)
    ) else report_mismatch(T_HSYNC, H_SYNC, $sampled(hs_low_cnt));

    a_hsync_period : assert property (@(posedge clk) disable iff (rst)
        ($fell(hsync) && hs_seen) |-> (hs_gap == H_TOTAL)
    ) else report_mismatch(T_HSYNC, H_TOTAL, $sampled(hs_gap));

    a_vsync_level : assert property (@(posedge clk) disable iff (rst)
        v2 |-> (vsync == e2_vs)
    ) else report_mismatch(T_VSYNC, $sampled(e2_vs), $sampled(vsync));

    a_vsync_width : assert property (@(posedge clk) disable iff (rst)
        $rose(vsync) |-> (vs_low_cnt == V_SYNC * H_TOTAL)
    ) else report_mismatch(T_VSYNC, V_SYNC * H_TOTAL, $sampled(vs_low_cnt));

    a_vsync_period : assert property (@(posedge clk) disable iff (rst)
        ($fell(vsync) && vs_seen) |-> (vs_gap == FRAME_CYCLES)
    ) else report_mismatch(T_VSYNC, FRAME_CYCLES, $sampled(vs_gap));

    a_blanking : assert property (@(posedge clk) disable iff (rst)
        (v2 && e2_cls == T_BLANK) |-> ({red, green, blue} == '0)
    ) else report_mismatch(T_BLANK, 0, $sampled({red, green, blue}));

    a_border : assert property (@(posedge clk) disable iff (rst)
        (v2 && e2_cls == T_BORDER) |-> ({red, green, blue} == e2_rgb)
    ) else report_mismatch(T_BORDER, $sampled(e2_rgb), $sampled({red, green, blue}));

    a_checker : assert property (@(posedge clk) disable iff (rst)
        (v2 && e2_cls == T_CHECKER) |-> ({red, green, blue} == e2_rgb)
    ) else report_mismatch(T_CHECKER, $sampled(e2_rgb), $sampled({red, green, blue}));

    a_stars : assert property (@(posedge clk) disable iff (rst)
        (v2 && e2_cls == T_STARS) |-> ({red, green, blue} == e2_rgb)
    ) else report_mismatch(T_STARS, $sampled(e2_rgb), $sampled({red, green, blue}));

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Run control
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    always @(posedge clk) begin
        cycle <= cycle + 1;
        if (cycle >= TIMEOUT_CYCLES) begin
            $display("timeout: two frames did not complete within %0d cycles", TIMEOUT_CYCLES);
            $display("CHECKS FAILED");
            $finish;
        end
    end

    initial begin
        int total_checks;
        int total_errors;
        int idle_tests;
        clk = 1'b0;
        rst = 1'b1;
        repeat (RESET_CYCLES) @(posedge clk);
        #DRIVE_DELAY rst = 1'b0;
        wait (frame_cnt == 2);
        repeat (3) @(posedge clk);                         // Drain the two pixels in flight
        #DRIVE_DELAY;
        total_checks = 0;
        total_errors = 0;
        idle_tests   = 0;
        for (int i = 0; i < N_TESTS; i++) begin
            $display("test %-8s %0d checks, %0d errors", test_name[i], chk_cnt[i], err_cnt[i]);
            if (chk_cnt[i] == 0) begin
                $display("test %s never reached any of its checks", test_name[i]);
                idle_tests = idle_tests + 1;
            end
            total_checks = total_checks + chk_cnt[i];
            total_errors = total_errors + err_cnt[i];
        end
        $display("checks: %0d passed, %0d failed", total_checks - total_errors, total_errors);
        if (total_errors == 0 && idle_tests == 0) begin
            $display("ALL CHECKS PASSED");
        end else begin
            $display("CHECKS FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- build.f
hdl/vga_pkg.sv
hdl/vga_timing.sv
hdl/lfsr_galois.sv
hdl/test_pattern.sv
hdl/starfield.sv
hdl/vga_pattern_top.sv
verification/tb_vga_pattern.sv

//--- Bender.yml
package:
  name: vga_pattern

# RTL in compile order, package first
sources:
  - hdl/vga_pkg.sv
  - hdl/vga_timing.sv
  - hdl/lfsr_galois.sv
  - hdl/test_pattern.sv
  - hdl/starfield.sv
  - hdl/vga_pattern_top.sv

  # Testbench, top module tb_vga_pattern
  - target: test
    files:
      - verification/tb_vga_pattern.sv
